// File: tb.f
logic/etx_pkg.sv
logic/etx_cfg_pkg.sv
logic/etx_fifo.sv
logic/etx_arbiter.sv
logic/etx_cfg.sv
logic/etx_protocol.sv
logic/etx.sv
verif/etx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the etx testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f tb.f --top-module etx_tb -o etx_sim &&
./obj_dir/etx_sim ||
{ echo "Simulation failed"; exit 1; }

// File: verif/etx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module etx_tb;
   import etx_pkg::*;
   import etx_cfg_pkg::*;

   localparam int MAX_CYCLES   = 2000;   // About 40 packets at 4 cycles plus APB traffic and margin
   localparam int DRAIN_CYCLES = 64;     // Longest backlog of 6 packets at 4 cycles with margin

   logic              clk;
   logic              rst;
   logic              wr_access;
   packet_t           wr_packet;
   logic              wr_wait;
   logic              rd_access;
   packet_t           rd_packet;
   logic              rd_wait;
   logic              tx_wr_wait;
   logic              tx_rd_wait;
   logic              tx_frame;
   beat_t             tx_data;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [APB_AW-1:0] paddr;
   logic [APB_DW-1:0] pwdata;
   logic [APB_DW-1:0] prdata;
   logic              pready;
   logic              pslverr;
   chipid_t           chipid;

   integer            seed;
   int                cycle_cnt;
   beat_t             exp_q[$];       // Expected beats in wire order
   logic              cfg_bypass;     // Register copy for the reference
   ctrlmode_t         cfg_ctrlmode;
   chipid_t           cfg_chipid;
   logic [APB_DW-1:0] rdata;
   logic              err;
   packet_t           pkts [8];

   etx i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;         // 20 ns period
   end

   // Watchdog
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      fail_run("Timeout: the test did not finish within the cycle limit");
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
      if (exp !== got)
         fail_run($sformatf("Mismatch %s exp=%h got=%h", name, exp, got));
   endtask

   // Expected beat 0 and beat 1 of one packet
   function automatic logic [2*BEAT_W-1:0] ref_beats(input packet_t p, input logic bypass,
                                                     input ctrlmode_t cm, input chipid_t id);
      ctrlmode_t  mode;
      logic [7:0] ctrl;
      beat_t      b0;
      beat_t      b1;
      mode = bypass ? cm : p[7:4];
      ctrl = {p[1], p[3:2], mode, 1'b0};     // Write, datamode, ctrlmode, spare
      b0   = {ctrl, p[39:8], id, 12'h000};
      b1   = {p[71:40], p[103:72]};          // Data, srcaddr
      return {b0, b1};
   endfunction

   task automatic expect_packet(input packet_t p);
      logic [2*BEAT_W-1:0] beats;
      beats = ref_beats(p, cfg_bypass, cfg_ctrlmode, cfg_chipid);
      exp_q.push_back(beats[2*BEAT_W-1:BEAT_W]);
      exp_q.push_back(beats[BEAT_W-1:0]);
   endtask

   task automatic make_packet(input logic is_rd, output packet_t p);
      logic [127:0] raw;
      raw  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      p    = raw[PW-1:0];
      p[1] = ~is_rd;                         // Write bit follows the channel
   endtask

   // Offer a packet and hold it while the queue is full
   task automatic send_packet(input logic is_rd, input packet_t p);
      logic held;
      @(posedge clk);
      #2;
      if (is_rd) begin
         rd_access = 1'b1;
         rd_packet = p;
      end else begin
         wr_access = 1'b1;
         wr_packet = p;
      end
      held = 1'b1;
      while (held) begin
         @(negedge clk);
         held = is_rd ? rd_wait : wr_wait;   // Low means taken on the next edge
      end
      @(posedge clk);
      #2;
      if (is_rd)
         rd_access = 1'b0;
      else
         wr_access = 1'b0;
   endtask

   task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                               input logic [APB_DW-1:0] wdata,
                               output logic [APB_DW-1:0] rd, output logic slv_err);
      @(posedge clk);
      #2;
      psel    = 1'b1;                        // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #2;
      penable = 1'b1;
      @(negedge clk);
      check_value("pready", 64'd1, 64'(pready));
      rd      = prdata;
      slv_err = pslverr;
      @(posedge clk);                        // Write lands here
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_config(input logic enable, input logic bypass, input ctrlmode_t mode);
      logic [APB_DW-1:0] rd_dummy;
      logic              slv_err;
      apb_transfer(1'b1, REG_CONFIG, {24'h0, mode, 2'b00, bypass, enable}, rd_dummy, slv_err);
      check_value("pslverr", 64'd0, 64'(slv_err));
      cfg_bypass   = bypass;
      cfg_ctrlmode = mode;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
         @(posedge clk);
         n++;
      end
      @(negedge clk);
      check_value("tx_frame", 64'd0, 64'(tx_frame));   // Link back to idle
   endtask

   task automatic send_alone(input logic is_rd);
      packet_t p;
      make_packet(is_rd, p);
      expect_packet(p);
      send_packet(is_rd, p);
      wait_drained();
   endtask

   // Beat checker
   always @(negedge clk) begin
      if (!rst && tx_frame) begin
         if (exp_q.size() == 0)
            fail_run("A beat was framed while none was expected");
         else
            check_value("tx_data", exp_q.pop_front(), tx_data);
      end else if (!rst) begin
         check_value("tx_data", 64'd0, tx_data);   // Idle data is zero
      end
   end

   initial begin
      seed         = 32'ha54a97bf;
      rst          = 1'b1;
      wr_access    = 1'b0;
      wr_packet    = '0;
      rd_access    = 1'b0;
      rd_packet    = '0;
      tx_wr_wait   = 1'b0;
      tx_rd_wait   = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      cfg_bypass   = 1'b0;
      cfg_ctrlmode = '0;
      cfg_chipid   = CHIPID_RESET;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      check_value("wr_wait", 64'd0, 64'(wr_wait));
      check_value("rd_wait", 64'd0, 64'(rd_wait));
      check_value("tx_frame", 64'd0, 64'(tx_frame));

      // Registers with reserved bits set on write
      apb_transfer(1'b1, REG_CONFIG, 32'hffff_ff5e, rdata, err);
      apb_transfer(1'b1, REG_CHIPID, 32'hdead_babc, rdata, err);
      apb_transfer(1'b1, 8'h0c, 32'hffff_ffff, rdata, err);   // Unmapped offset is dropped
      check_value("pslverr", 64'd1, 64'(err));
      apb_transfer(1'b0, REG_CONFIG, '0, rdata, err);
      check_value("prdata", 64'h52, 64'(rdata));
      check_value("pslverr", 64'd0, 64'(err));
      apb_transfer(1'b0, REG_CHIPID, '0, rdata, err);
      check_value("prdata", 64'habc, 64'(rdata));
      check_value("chipid", 64'habc, 64'(chipid));
      apb_transfer(1'b0, 8'h08, '0, rdata, err);
      check_value("pslverr", 64'd1, 64'(err));
      cfg_chipid = 12'habc;

      // Isolated packets on both channels
      write_config(1'b1, 1'b0, 4'h0);
      for (int i = 0; i < 8; i++)
         send_alone(i[0]);

      // Read requests ahead of writes
      write_config(1'b0, 1'b0, 4'h0);
      for (int i = 0; i < 6; i++) begin
         make_packet(i >= 3, pkts[i]);
         send_packet(i >= 3, pkts[i]);
      end
      for (int i = 3; i < 6; i++)
         expect_packet(pkts[i]);
      for (int i = 0; i < 3; i++)
         expect_packet(pkts[i]);
      write_config(1'b1, 1'b0, 4'h0);
      wait_drained();

      // Ctrlmode override
      write_config(1'b1, 1'b1, 4'ha);
      for (int i = 0; i < 4; i++)
         send_alone(i[0]);
      write_config(1'b1, 1'b0, 4'h0);

      // Far end holds reads
      @(posedge clk);
      #2;
      tx_rd_wait = 1'b1;
      for (int i = 0; i < 4; i++) begin
         make_packet(i < 2, pkts[i]);
         if (i >= 2)
            expect_packet(pkts[i]);
         send_packet(i < 2, pkts[i]);
      end
      wait_drained();
      repeat (5) @(negedge clk);               // Reads stay queued
      expect_packet(pkts[0]);
      expect_packet(pkts[1]);
      @(posedge clk);
      #2;
      tx_rd_wait = 1'b0;
      wait_drained();

      // Far end holds writes
      @(posedge clk);
      #2;
      tx_wr_wait = 1'b1;
      make_packet(1'b0, pkts[0]);
      make_packet(1'b1, pkts[1]);
      expect_packet(pkts[1]);
      send_packet(1'b0, pkts[0]);
      send_packet(1'b1, pkts[1]);
      wait_drained();
      repeat (5) @(negedge clk);               // Write stays queued
      expect_packet(pkts[0]);
      @(posedge clk);
      #2;
      tx_wr_wait = 1'b0;
      wait_drained();

      // Full write queue plus one held at the door
      write_config(1'b0, 1'b0, 4'h0);
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         check_value("wr_wait", 64'd0, 64'(wr_wait));
         make_packet(1'b0, pkts[i]);
         expect_packet(pkts[i]);
         send_packet(1'b0, pkts[i]);
      end
      check_value("wr_wait", 64'd1, 64'(wr_wait));
      make_packet(1'b0, pkts[QUEUE_DEPTH]);
      expect_packet(pkts[QUEUE_DEPTH]);
      fork
         send_packet(1'b0, pkts[QUEUE_DEPTH]);
         write_config(1'b1, 1'b0, 4'h0);
      join
      wait_drained();

      if (exp_q.size() != 0) begin
         fail_run("Expected beats were left over at the end of the test");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: logic/etx.sv
`timescale 1ns/1ps
`default_nettype none

module etx (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           wr_access,    // Remote write channel
   input  etx_pkg::packet_t               wr_packet,
   output logic                           wr_wait,
   input  logic                           rd_access,    // Remote read request channel
   input  etx_pkg::packet_t               rd_packet,
   output logic                           rd_wait,
   input  logic                           tx_wr_wait,   // Far-end pushback
   input  logic                           tx_rd_wait,
   output logic                           tx_frame,
   output etx_pkg::beat_t                 tx_data,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [etx_cfg_pkg::APB_AW-1:0] paddr,
   input  logic [etx_cfg_pkg::APB_DW-1:0] pwdata,
   output logic [etx_cfg_pkg::APB_DW-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   output etx_pkg::chipid_t               chipid
);
   import etx_pkg::*;

   logic      wrq_access;
   packet_t   wrq_packet;
   logic      wrq_pop;
   logic      rdq_access;
   packet_t   rdq_packet;
   logic      rdq_pop;
   logic      tx_enable;
   logic      ctrlmode_bypass;
   ctrlmode_t ctrlmode;
   logic      etx_busy;
   logic      etx_access;      // Arbiter to framer
   packet_t   etx_packet;

   etx_fifo #(.DEPTH(QUEUE_DEPTH)) i_wr_fifo (
      .clk      (clk),
      .rst      (rst),
      .access   (wr_access),
      .packet   (wr_packet),
      .wait_out (wr_wait),
      .q_pop    (wrq_pop),
      .q_access (wrq_access),
      .q_packet (wrq_packet)
   );

   etx_fifo #(.DEPTH(QUEUE_DEPTH)) i_rd_fifo (
      .clk      (clk),
      .rst      (rst),
      .access   (rd_access),
      .packet   (rd_packet),
      .wait_out (rd_wait),
      .q_pop    (rdq_pop),
      .q_access (rdq_access),
      .q_packet (rdq_packet)
   );

   etx_arbiter i_arbiter (
      .clk             (clk),
      .rst             (rst),
      .rdq_access      (rdq_access),
      .rdq_packet      (rdq_packet),
      .wrq_access      (wrq_access),
      .wrq_packet      (wrq_packet),
      .rdq_pop         (rdq_pop),
      .wrq_pop         (wrq_pop),
      .tx_rd_wait      (tx_rd_wait),
      .tx_wr_wait      (tx_wr_wait),
      .tx_enable       (tx_enable),
      .ctrlmode_bypass (ctrlmode_bypass),
      .ctrlmode        (ctrlmode),
      .etx_busy        (etx_busy),
      .etx_access      (etx_access),
      .etx_packet      (etx_packet)
   );

   etx_cfg i_cfg (
      .clk             (clk),
      .rst             (rst),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .tx_enable       (tx_enable),
      .ctrlmode_bypass (ctrlmode_bypass),
      .ctrlmode        (ctrlmode),
      .chipid          (chipid)
   );

   etx_protocol i_protocol (
      .clk        (clk),
      .rst        (rst),
      .etx_access (etx_access),
      .etx_packet (etx_packet),
      .chipid     (chipid),       // Also a top-level output
      .etx_busy   (etx_busy),
      .tx_frame   (tx_frame),
      .tx_data    (tx_data)
   );

endmodule

`default_nettype wire

// File: logic/etx_protocol.sv
`timescale 1ns/1ps
`default_nettype none

module etx_protocol (
   input  logic             clk,
   input  logic             rst,
   input  logic             etx_access,   // Packet offered by arbiter
   input  etx_pkg::packet_t etx_packet,
   input  etx_pkg::chipid_t chipid,       // Inserted into beat 0
   output logic             etx_busy,     // Beat 1 still to go
   output logic             tx_frame,
   output etx_pkg::beat_t   tx_data
);
   import etx_pkg::*;

   logic [CTRL_W-1:0] ctrl_byte;
   beat_t             beat0;
   beat_t             beat1;
   beat_t             beat1_q;    // Second half held for next cycle
   logic              beat_cnt;   // 1 while beat 1 is pending

   // Write, datamode, ctrlmode, spare 0
   assign ctrl_byte = {etx_packet[WRITE_POS],
                       etx_packet[DATAMODE_LSB +: DATAMODE_W],
                       etx_packet[CTRLMODE_LSB +: CTRLMODE_W],
                       1'b0};

   assign beat0 = {ctrl_byte,
                   etx_packet[DSTADDR_LSB +: AW],
                   chipid,
                   {B0_PAD_W{1'b0}}};

   assign beat1 = {etx_packet[DATA_LSB +: DW],
                   etx_packet[SRCADDR_LSB +: AW]};

   assign etx_busy = beat_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         beat_cnt <= 1'b0;
         tx_frame <= 1'b0;
         tx_data  <= '0;
      end else if (etx_access) begin
         beat_cnt <= 1'b1;          // Beat 0 now, beat 1 next
         tx_frame <= 1'b1;
         tx_data  <= beat0;
      end else if (beat_cnt) begin
         beat_cnt <= 1'b0;
         tx_frame <= 1'b1;
         tx_data  <= beat1_q;
      end else begin
         tx_frame <= 1'b0;          // Idle link
         tx_data  <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (etx_access) begin
         beat1_q <= beat1;
      end
   end

endmodule

`default_nettype wire

// File: logic/etx_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module etx_cfg (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [etx_cfg_pkg::APB_AW-1:0] paddr,
   input  logic [etx_cfg_pkg::APB_DW-1:0] pwdata,
   output logic [etx_cfg_pkg::APB_DW-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   output logic                           tx_enable,
   output logic                           ctrlmode_bypass,
   output etx_pkg::ctrlmode_t             ctrlmode,
   output etx_pkg::chipid_t               chipid
);
   import etx_pkg::*;
   import etx_cfg_pkg::*;

   logic access_ph;     // APB access phase
   logic config_hit;
   logic chipid_hit;
   logic wr_en;

   assign access_ph  = psel & penable;
   assign config_hit = (paddr == REG_CONFIG);
   assign chipid_hit = (paddr == REG_CHIPID);
   assign wr_en      = access_ph & pwrite;

   assign pready  = 1'b1;                                  // No wait states
   assign pslverr = access_ph & ~(config_hit | chipid_hit); // Unmapped offset

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_enable       <= CONFIG_RESET[CFG_TX_ENABLE_BIT];
         ctrlmode_bypass <= CONFIG_RESET[CFG_BYPASS_BIT];
         ctrlmode        <= CONFIG_RESET[CFG_CTRLMODE_LSB +: CTRLMODE_W];
      end else if (wr_en && config_hit) begin
         tx_enable       <= pwdata[CFG_TX_ENABLE_BIT];
         ctrlmode_bypass <= pwdata[CFG_BYPASS_BIT];
         ctrlmode        <= pwdata[CFG_CTRLMODE_LSB +: CTRLMODE_W];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         chipid <= CHIPID_RESET;
      end else if (wr_en && chipid_hit) begin
         chipid <= pwdata[ID_W-1:0];
      end
   end

   // Read mux, reserved bits stay 0
   always_comb begin
      prdata = '0;
      if (config_hit) begin
         prdata[CFG_TX_ENABLE_BIT]                = tx_enable;
         prdata[CFG_BYPASS_BIT]                   = ctrlmode_bypass;
         prdata[CFG_CTRLMODE_LSB +: CTRLMODE_W]   = ctrlmode;
      end else if (chipid_hit) begin
         prdata[ID_W-1:0] = chipid;
      end
   end

endmodule

`default_nettype wire

// File: logic/etx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module etx_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  logic               rdq_access,       // Read request queue not empty
   input  etx_pkg::packet_t   rdq_packet,
   input  logic               wrq_access,       // Write queue not empty
   input  etx_pkg::packet_t   wrq_packet,
   output logic               rdq_pop,
   output logic               wrq_pop,
   input  logic               tx_rd_wait,       // Far end holds reads
   input  logic               tx_wr_wait,       // Far end holds writes
   input  logic               tx_enable,
   input  logic               ctrlmode_bypass,
   input  etx_pkg::ctrlmode_t ctrlmode,         // Override value
   input  logic               etx_busy,         // Framer on beat 0
   output logic               etx_access,
   output etx_pkg::packet_t   etx_packet
);
   import etx_pkg::*;

   logic    slot_free;
   logic    pick;
   packet_t pick_packet;
   packet_t next_packet;

   // Framer takes one packet per two beats, so a packet already
   // offered this cycle also blocks the next pick
   assign slot_free = tx_enable & ~etx_busy & ~etx_access;

   // Fixed priority, read requests first
   assign rdq_pop = slot_free & rdq_access & ~tx_rd_wait;
   assign wrq_pop = slot_free & wrq_access & ~tx_wr_wait & ~rdq_pop;
   assign pick    = rdq_pop | wrq_pop;

   assign pick_packet = rdq_pop ? rdq_packet : wrq_packet;

   always_comb begin
      next_packet = pick_packet;
      if (ctrlmode_bypass) begin
         next_packet[CTRLMODE_LSB +: CTRLMODE_W] = ctrlmode;   // Register value wins
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         etx_access <= 1'b0;
      end else begin
         etx_access <= pick;             // One cycle after the pop
      end
   end

   always_ff @(posedge clk) begin
      if (pick) begin
         etx_packet <= next_packet;
      end
   end

endmodule

`default_nettype wire

// File: logic/etx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module etx_fifo #(
   parameter int DEPTH = etx_pkg::QUEUE_DEPTH   // Power of two
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             access,     // Sender offers a packet
   input  etx_pkg::packet_t packet,
   output logic             wait_out,   // Full, sender holds
   input  logic             q_pop,      // Arbiter takes the head
   output logic             q_access,   // Head is valid
   output etx_pkg::packet_t q_packet
);
   import etx_pkg::*;

   packet_t                  mem [DEPTH];   // Circular buffer
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH):0]   count;         // Occupancy, 0..DEPTH
   logic                     push;
   logic                     pop;

   // Count never exceeds DEPTH, so its MSB alone means full
   assign wait_out = count[$clog2(DEPTH)];
   assign q_access = (count != '0);
   assign q_packet = mem[rd_ptr];           // Head straight from storage

   assign push = access & ~wait_out;        // Taken only when not full
   assign pop  = q_pop & q_access;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= packet;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;        // Wraps at DEPTH
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;        // Next entry shows next cycle
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/etx_cfg_pkg.sv
`default_nettype none

package etx_cfg_pkg;

   localparam int APB_AW = 8;   // Byte offsets
   localparam int APB_DW = 32;

   // Register offsets
   localparam logic [APB_AW-1:0] REG_CONFIG = 8'h00;
   localparam logic [APB_AW-1:0] REG_CHIPID = 8'h04;

   // REG_CONFIG bits
   localparam int CFG_TX_ENABLE_BIT = 0;
   localparam int CFG_BYPASS_BIT    = 1;   // Ctrlmode override on
   localparam int CFG_CTRLMODE_LSB  = 4;   // Bits 7..4

   // Link comes up disabled
   localparam logic [APB_DW-1:0] CONFIG_RESET = 32'h0000_0000;
   localparam logic [11:0]       CHIPID_RESET = 12'h000;

endpackage

`default_nettype wire

// File: logic/etx_pkg.sv
`default_nettype none

package etx_pkg;

   localparam int PW          = 104;  // Link packet
   localparam int AW          = 32;   // Address fields
   localparam int DW          = 32;   // Data field
   localparam int BEAT_W      = 64;   // Framed beat on the wire
   localparam int CTRL_W      = 8;    // Control byte in beat 0
   localparam int ID_W        = 12;   // Chip ID
   localparam int QUEUE_DEPTH = 4;    // Request queue entries

   // Packet fields, bit 0 is not carried on the link
   localparam int WRITE_POS    = 1;
   localparam int DATAMODE_LSB = 2;   // Bits 3..2
   localparam int DATAMODE_W   = 2;
   localparam int CTRLMODE_LSB = 4;   // Bits 7..4
   localparam int CTRLMODE_W   = 4;
   localparam int DSTADDR_LSB  = 8;   // Bits 39..8
   localparam int DATA_LSB     = 40;  // Bits 71..40
   localparam int SRCADDR_LSB  = 72;  // Bits 103..72

   // Zero pad below the chip ID in beat 0
   localparam int B0_PAD_W = BEAT_W - CTRL_W - AW - ID_W;

   typedef logic [PW-1:0]         packet_t;
   typedef logic [BEAT_W-1:0]     beat_t;
   typedef logic [CTRLMODE_W-1:0] ctrlmode_t;
   typedef logic [ID_W-1:0]       chipid_t;

endpackage

`default_nettype wire
